/* bench/rv_core_cases.txt */
// Each token: bits 71:69 kind (1 word, 2 expected, 3 reset, 4 end), 68:64 rd, 63:0 value
// Kind 1 holds the instruction word in the low 32 bits, kind 2 the expected rd and result
// I-type operations, LUI and x2 at reset
2000000000FFB00093 200000000000710193 2000000000FFF0A213
20000000000050B293 20000000000F00C313 200000000055506393
20000000007F00F413 200000000002839493 200000000003C0D513
20000000004210D593 200000000080000637 2000000000123456B7
200000000000000063
41FFFFFFFFFFFFFFFB 430000000000000087 440000000000000001
450000000000000000 46FFFFFFFFFFFFFF0B 470000000000000555
4800000000000007F0 490005550000000000 4A000000000000000F
4BFFFFFFFFFFFFFFFF 4CFFFFFFFF80000000 4D0000000012345000
800000000000000000
// R-type operations with negative operands and a shift of 35
2000000000FF900093 200000000002300113 2000000000002081B3
200000000040208233 2000000000002092B3 20000000000020A333
20000000000020B3B3 20000000000020C433 20000000000020D4B3
20000000004020D533 20000000000020E5B3 20000000000020F633
2000000000001136B3 200000000000112733 200000000000000063
41FFFFFFFFFFFFFFF9 420000000000000023 43000000000000001C
44FFFFFFFFFFFFFFD6 45FFFFFFC800000000 460000000000000001
470000000000000000 48FFFFFFFFFFFFFFDA 49000000001FFFFFFF
4AFFFFFFFFFFFFFFFF 4BFFFFFFFFFFFFFFFB 4C0000000000000021
4D0000000000000001 4E0000000000000000
800000000000000000
// Dependent chain, write to x0 and every branch taken and not taken
200000000000100093 2000000000001080B3 2000000000001080B3
2000000000001080B3 200000000000500013 200000000000900193
200000000000009463 200000000000100293 200000000000308463
200000000000600313 20000000000030C463 200000000000200293
20000000000030D463 200000000000700393 2000000000FFF00213
200000000000126463 200000000000800413 200000000000127463
200000000000300293 200000000000124463 200000000000400293
200000000000125463 200000000000900493 200000000000318463
200000000000500293 200000000000319463 200000000000A00513
200000000000000063
410000000000000001 410000000000000002 410000000000000004
410000000000000008 430000000000000009 460000000000000006
470000000000000007 44FFFFFFFFFFFFFFFF 480000000000000008
490000000000000009 4A000000000000000A
800000000000000000
// Reset while running restarts with x2 back at 128
200000000000300093 200000000000208133 200000000000000063
410000000000000003 420000000000000083 600000000000000000
410000000000000003 420000000000000083 800000000000000000

/* build.f */
hw/rv_isa_pkg.sv
hw/rv_pipe_pkg.sv
hw/rv_fetch.sv
hw/rv_decode.sv
hw/rv_regfile.sv
hw/rv_execute.sv
hw/rv_core.sv
bench/rv_core_tb.sv

/* Makefile */
# Verilator build and run for the RV64I core testbench

VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_TEXT ?= *** PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qF "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/rv_core_tb.sv */
// Testbench for the RV64I core that runs the programs of the cases file and checks each retirement
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;
();

  localparam int case_depth = 256;
  localparam int quiet_cycles = 20;

  // Entry kind in the top three bits of each cases word
  localparam logic [2:0] kind_none   = 3'd0;
  localparam logic [2:0] kind_word   = 3'd1;
  localparam logic [2:0] kind_expect = 3'd2;
  localparam logic [2:0] kind_reset  = 3'd3;
  localparam logic [2:0] kind_end    = 3'd4;

  typedef logic [7:0]  case_idx_t;
  typedef logic [71:0] case_entry_t;

  logic       clk_div;
  logic       reset;
  logic       run;
  logic       imem_we;
  imem_addr_t imem_addr;
  inst_t      imem_wdata;
  logic       result_valid;
  reg_idx_t   result_rd;
  word_t      result;

  case_entry_t cases [case_depth];
  case_idx_t   pos;
  int          cycle_count = 0;
  int          cycle_limit = 0; // Zero until the cases file is read
  int          program_count;

  rv_core rv_core_i (
    .clk_div      (clk_div),
    .reset        (reset),
    .run          (run),
    .imem_we      (imem_we),
    .imem_addr    (imem_addr),
    .imem_wdata   (imem_wdata),
    .result_valid (result_valid),
    .result_rd    (result_rd),
    .result       (result)
  );

  initial begin
    clk_div = 1'b0;
    forever #5 clk_div = ~clk_div;
  end

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input word_t got, input word_t expected);
    fail_run($sformatf("CHECK FAILED at %0t: %s got 0x%016h expected 0x%016h",
                       $time, name, got, expected));
  endtask

  always @(posedge clk_div) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
      fail_run($sformatf("Timeout after %0d cycles waiting for a retirement", cycle_count));
    end
  end

  function automatic int count_words();
    int n;
    n = 0;
    for (int i = 0; i < case_depth; i++) begin
      if (cases[case_idx_t'(i)][71:69] == kind_word) begin
        n++;
      end
    end
    return n;
  endfunction

  task automatic pulse_reset();
    @(posedge clk_div);
    reset <= 1'b0;
    repeat (2) @(posedge clk_div);
    reset <= 1'b1;
  endtask

  // Program words go to consecutive word addresses from 0
  task automatic load_program();
    int n;
    n = 0;
    while (cases[pos][71:69] == kind_word) begin
      @(posedge clk_div);
      imem_we    <= 1'b1;
      imem_addr  <= imem_addr_t'(n);
      imem_wdata <= cases[pos][31:0];
      n++;
      pos++;
    end
    @(posedge clk_div);
    imem_we <= 1'b0;
  endtask

  task automatic check_retire(input reg_idx_t exp_rd, input word_t exp_value);
    do begin
      @(negedge clk_div); // Outputs settled mid cycle
    end while (!result_valid);
    assert (result_rd == exp_rd)
    else report_mismatch("result_rd", word_t'(result_rd), word_t'(exp_rd));
    assert (result == exp_value)
    else report_mismatch("result", result, exp_value);
  endtask

  task automatic check_quiet();
    repeat (quiet_cycles) begin
      @(negedge clk_div);
      assert (!result_valid)
      else fail_run($sformatf("Unexpected retirement to x%0d at %0t after the last expected one",
                              result_rd, $time));
    end
  endtask

  initial begin
    reset         = 1'b0;
    run           = 1'b0;
    imem_we       = 1'b0;
    imem_addr     = '0;
    imem_wdata    = '0;
    pos           = '0;
    program_count = 0;
    void'($urandom(32'h32a4_5bc6));
    for (int i = 0; i < case_depth; i++) begin
      cases[case_idx_t'(i)] = '0;
    end
    $readmemh("bench/rv_core_cases.txt", cases);
    cycle_limit = 40 * count_words() + 100;

    repeat (2) @(posedge clk_div);
    reset <= 1'b1;

    while (cases[pos][71:69] != kind_none) begin
      program_count++;
      load_program();
      pulse_reset();
      run <= 1'b1;
      while (cases[pos][71:69] != kind_end) begin
        case (cases[pos][71:69])
          kind_expect: check_retire(cases[pos][68:64], cases[pos][63:0]);
          kind_reset:  pulse_reset(); // Restart in the middle of a program
          default:     fail_run($sformatf("Malformed entry %0d in the cases file", pos));
        endcase
        pos++;
      end
      check_quiet();
      @(posedge clk_div);
      run <= 1'b0;
      pos++;
    end

    if (program_count == 0) begin
      fail_run("The cases file holds no programs");
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* hw/rv_core.sv */
// RV64I integer core top level joining fetch, decode, register file and execute
`timescale 1ns/1ps
`default_nettype none

module rv_core
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;
(
  input  logic       clk_div,
  input  logic       reset,
  input  logic       run,
  input  logic       imem_we,
  input  imem_addr_t imem_addr,
  input  inst_t      imem_wdata,
  output logic       result_valid,
  output reg_idx_t   result_rd,
  output word_t      result
);

  fetch_t   fetch_rec;
  issue_t   issue_rec;
  retire_t  retire_rec;
  logic     stall;
  logic     redirect;
  pc_t      redirect_pc;
  reg_idx_t rs1_idx;
  reg_idx_t rs2_idx;
  word_t    rs1_value;
  word_t    rs2_value;

  rv_fetch fetch_i (
    .clk_div     (clk_div),
    .reset       (reset),
    .run         (run),
    .imem_we     (imem_we),
    .imem_addr   (imem_addr),
    .imem_wdata  (imem_wdata),
    .stall       (stall),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .fetch_out   (fetch_rec)
  );

  rv_decode decode_i (
    .clk_div   (clk_div),
    .reset     (reset),
    .fetch_in  (fetch_rec),
    .redirect  (redirect),
    .rs1_value (rs1_value),
    .rs2_value (rs2_value),
    .retire_in (retire_rec),
    .rs1_idx   (rs1_idx),
    .rs2_idx   (rs2_idx),
    .stall     (stall),
    .issue_out (issue_rec)
  );

  rv_regfile regfile_i (
    .clk_div   (clk_div),
    .reset     (reset),
    .rs1_idx   (rs1_idx),
    .rs2_idx   (rs2_idx),
    .write_in  (retire_rec),
    .rs1_value (rs1_value),
    .rs2_value (rs2_value)
  );

  rv_execute execute_i (
    .clk_div     (clk_div),
    .reset       (reset),
    .issue_in    (issue_rec),
    .retire_out  (retire_rec),
    .redirect    (redirect),
    .redirect_pc (redirect_pc)
  );

  assign result_valid = retire_rec.valid;
  assign result_rd    = retire_rec.rd;
  assign result       = retire_rec.value;

endmodule

`default_nettype wire

/* hw/rv_execute.sv */
// Execute stage with the ALU, branch resolution and the retire register
`timescale 1ns/1ps
`default_nettype none

module rv_execute
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;
(
  input  logic    clk_div,
  input  logic    reset,
  input  issue_t  issue_in,
  output retire_t retire_out,
  output logic    redirect,
  output pc_t     redirect_pc
);

  word_t  a;
  word_t  b;
  shamt_t shamt;
  word_t  alu_result;
  logic   taken;

  assign a     = issue_in.op_a;
  assign b     = issue_in.op_b;
  assign shamt = b[5:0];

  always_comb begin
    case (issue_in.op)
      alu_add:  alu_result = a + b;
      alu_sub:  alu_result = a - b;
      alu_sll:  alu_result = a << shamt;
      alu_slt:  alu_result = word_t'($signed(a) < $signed(b));
      alu_sltu: alu_result = word_t'(a < b);
      alu_xor:  alu_result = a ^ b;
      alu_srl:  alu_result = a >> shamt;
      alu_sra:  alu_result = $signed(a) >>> shamt;
      alu_or:   alu_result = a | b;
      alu_and:  alu_result = a & b;
      alu_lui:  alu_result = issue_in.imm;
      default:  alu_result = '0; // Branches produce no value
    endcase
  end

  always_comb begin
    case (issue_in.op)
      alu_beq:  taken = (a == b);
      alu_bne:  taken = (a != b);
      alu_blt:  taken = ($signed(a) < $signed(b));
      alu_bge:  taken = ($signed(a) >= $signed(b));
      alu_bltu: taken = (a < b);
      alu_bgeu: taken = (a >= b);
      default:  taken = 1'b0;
    endcase
  end

  // Lasts one cycle since decode sends a bubble behind it
  assign redirect    = issue_in.valid && issue_in.branch && taken;
  assign redirect_pc = issue_in.pc + issue_in.imm;

  always_ff @(posedge clk_div) begin
    if (!reset) begin
      retire_out.valid <= 1'b0;
    end else begin
      retire_out.valid <= issue_in.valid && issue_in.rd_we && issue_in.rd != '0;
      retire_out.rd    <= issue_in.rd;
      retire_out.value <= alu_result;
    end
  end

endmodule

`default_nettype wire

/* hw/rv_regfile.sv */
// Integer register file with two read ports, one write port, x0 hardwired and x2 preset
`timescale 1ns/1ps
`default_nettype none

module rv_regfile
  import rv_isa_pkg::*;
(
  input  logic                 clk_div,
  input  logic                 reset,
  input  reg_idx_t             rs1_idx,
  input  reg_idx_t             rs2_idx,
  input  rv_pipe_pkg::retire_t write_in,
  output word_t                rs1_value,
  output word_t                rs2_value
);

  word_t regs [1:31]; // x0 has no storage

  always_ff @(posedge clk_div) begin
    if (!reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= (i == 2) ? rv_pipe_pkg::sp_reset_value : '0;
      end
    end else if (write_in.valid && write_in.rd != '0) begin
      regs[write_in.rd] <= write_in.value;
    end
  end

  assign rs1_value = (rs1_idx == '0) ? '0 : regs[rs1_idx];
  assign rs2_value = (rs2_idx == '0) ? '0 : regs[rs2_idx];

endmodule

`default_nettype wire

/* hw/rv_decode.sv */
// Decode stage with field split, immediates, ALU op selection and the hazard interlock
`timescale 1ns/1ps
`default_nettype none

module rv_decode
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;
(
  input  logic     clk_div,
  input  logic     reset,
  input  fetch_t   fetch_in,
  input  logic     redirect,
  input  word_t    rs1_value,
  input  word_t    rs2_value,
  input  retire_t  retire_in,
  output reg_idx_t rs1_idx,
  output reg_idx_t rs2_idx,
  output logic     stall,
  output issue_t   issue_out
);

  inst_t    inst;
  opcode_t  opcode;
  funct3_t  funct3;
  funct7_t  funct7;
  reg_idx_t rd;
  word_t    imm_i;
  word_t    imm_u;
  word_t    imm_b;
  logic     use_rs1;
  logic     use_rs2;
  logic     rs1_busy;
  logic     rs2_busy;
  logic     exec_writes;
  logic     shift_ok;
  issue_t   issue_d;

  function automatic alu_op_t alu_from_funct3(input funct3_t f3, input logic alt);
    alu_op_t op;
    case (f3)
      funct3_add_sub: op = alt ? alu_sub : alu_add;
      funct3_sll:     op = alu_sll;
      funct3_slt:     op = alu_slt;
      funct3_sltu:    op = alu_sltu;
      funct3_xor:     op = alu_xor;
      funct3_srl_sra: op = alt ? alu_sra : alu_srl;
      funct3_or:      op = alu_or;
      default:        op = alu_and;
    endcase
    return op;
  endfunction

  assign inst    = fetch_in.inst;
  assign opcode  = inst[6:0];
  assign rd      = inst[11:7];
  assign funct3  = inst[14:12];
  assign rs1_idx = inst[19:15];
  assign rs2_idx = inst[24:20];
  assign funct7  = inst[31:25];

  assign imm_i = {{52{inst[31]}}, inst[31:20]};
  assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
  assign imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

  // RV64 shift immediates carry shamt[5] in bit 25
  assign shift_ok = (funct7[6:1] == funct7_base[6:1]) ||
                    (funct3 == funct3_srl_sra && funct7[6:1] == funct7_alt[6:1]);

  always_comb begin
    use_rs1        = 1'b0;
    use_rs2        = 1'b0;
    issue_d.op     = alu_add;
    issue_d.rd     = rd;
    issue_d.rd_we  = 1'b0; // Unknown encodings become bubbles
    issue_d.op_a   = rs1_value;
    issue_d.op_b   = rs2_value;
    issue_d.imm    = imm_i;
    issue_d.pc     = fetch_in.pc;
    issue_d.branch = 1'b0;
    case (opcode)
      opcode_op: begin
        use_rs1       = 1'b1;
        use_rs2       = 1'b1;
        issue_d.op    = alu_from_funct3(funct3, funct7 == funct7_alt);
        issue_d.rd_we = (funct7 == funct7_base) || (funct7 == funct7_alt &&
                        (funct3 == funct3_add_sub || funct3 == funct3_srl_sra));
      end
      opcode_op_imm: begin
        use_rs1       = 1'b1;
        issue_d.op_b  = imm_i;
        issue_d.op    = alu_from_funct3(funct3, funct3 == funct3_srl_sra && funct7[5]);
        issue_d.rd_we = (funct3 != funct3_sll && funct3 != funct3_srl_sra) || shift_ok;
      end
      opcode_lui: begin
        issue_d.op    = alu_lui;
        issue_d.imm   = imm_u;
        issue_d.rd_we = 1'b1;
      end
      opcode_branch: begin
        use_rs1        = 1'b1;
        use_rs2        = 1'b1;
        issue_d.imm    = imm_b;
        issue_d.branch = 1'b1;
        case (funct3)
          funct3_beq:  issue_d.op = alu_beq;
          funct3_bne:  issue_d.op = alu_bne;
          funct3_blt:  issue_d.op = alu_blt;
          funct3_bge:  issue_d.op = alu_bge;
          funct3_bltu: issue_d.op = alu_bltu;
          funct3_bgeu: issue_d.op = alu_bgeu;
          default:     issue_d.branch = 1'b0;
        endcase
      end
      default: ;
    endcase
    issue_d.valid = fetch_in.valid && !redirect;
  end

  // Interlock against the instruction in execute and the pending register write
  assign exec_writes = issue_out.valid && issue_out.rd_we;
  assign rs1_busy = use_rs1 && rs1_idx != '0 &&
                    ((exec_writes && issue_out.rd == rs1_idx) ||
                     (retire_in.valid && retire_in.rd == rs1_idx));
  assign rs2_busy = use_rs2 && rs2_idx != '0 &&
                    ((exec_writes && issue_out.rd == rs2_idx) ||
                     (retire_in.valid && retire_in.rd == rs2_idx));
  assign stall = fetch_in.valid && (rs1_busy || rs2_busy);

  always_ff @(posedge clk_div) begin
    if (!reset) begin
      issue_out.valid <= 1'b0;
    end else begin
      issue_out       <= issue_d;
      issue_out.valid <= issue_d.valid && !stall; // Bubble while a source is pending
    end
  end

endmodule

`default_nettype wire

/* hw/rv_fetch.sv */
// Fetch stage holding the loadable instruction memory, the pc and the fetch register
`timescale 1ns/1ps
`default_nettype none

module rv_fetch
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;
(
  input  logic       clk_div,
  input  logic       reset,
  input  logic       run,
  input  logic       imem_we,
  input  imem_addr_t imem_addr,
  input  inst_t      imem_wdata,
  input  logic       stall,
  input  logic       redirect,
  input  pc_t        redirect_pc,
  output fetch_t     fetch_out
);

  inst_t      imem [imem_words];
  pc_t        pc;
  imem_addr_t rd_addr;
  inst_t      rd_data;

  assign rd_addr = pc[2 +: $bits(imem_addr_t)]; // Word address, wraps past the end
  assign rd_data = imem[rd_addr];

  always_ff @(posedge clk_div) begin
    if (imem_we) begin
      imem[imem_addr] <= imem_wdata;
    end
  end

  always_ff @(posedge clk_div) begin
    if (!reset) begin
      pc              <= '0;
      fetch_out.valid <= 1'b0;
    end else if (redirect) begin
      pc              <= redirect_pc; // Drop the younger fetch
      fetch_out.valid <= 1'b0;
    end else if (!stall) begin
      fetch_out.valid <= run;
      if (run) begin
        fetch_out.pc   <= pc;
        fetch_out.inst <= rd_data;
        pc             <= pc + 64'd4;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/rv_pipe_pkg.sv */
// Pipeline sizes, reset values and the stage-to-stage records of the core
`default_nettype none

package rv_pipe_pkg;

  import rv_isa_pkg::*;

  localparam int imem_words = 64;

  typedef logic [$clog2(imem_words)-1:0] imem_addr_t;
  typedef logic [xlen-1:0]               pc_t;

  localparam word_t sp_reset_value = 64'd128; // Initial stack pointer in x2

  typedef struct packed {
    logic  valid;
    pc_t   pc;
    inst_t inst;
  } fetch_t;

  typedef struct packed {
    logic     valid;
    alu_op_t  op;
    reg_idx_t rd;
    logic     rd_we;
    word_t    op_a;
    word_t    op_b;   // rs2 value or I immediate
    word_t    imm;
    pc_t      pc;
    logic     branch;
  } issue_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
    word_t    value;
  } retire_t;

endpackage

`default_nettype wire

/* hw/rv_isa_pkg.sv */
// RV64I instruction set definitions covering field types, opcodes, function codes and ALU ops
`default_nettype none

package rv_isa_pkg;

  localparam int xlen = 64;

  typedef logic [xlen-1:0] word_t;
  typedef logic [31:0]     inst_t;
  typedef logic [4:0]      reg_idx_t;
  typedef logic [5:0]      shamt_t;
  typedef logic [6:0]      opcode_t;
  typedef logic [2:0]      funct3_t;
  typedef logic [6:0]      funct7_t;

  localparam opcode_t opcode_op     = 7'b0110011;
  localparam opcode_t opcode_op_imm = 7'b0010011;
  localparam opcode_t opcode_lui    = 7'b0110111;
  localparam opcode_t opcode_branch = 7'b1100011;

  // Register and immediate ALU group
  localparam funct3_t funct3_add_sub = 3'b000;
  localparam funct3_t funct3_sll     = 3'b001;
  localparam funct3_t funct3_slt     = 3'b010;
  localparam funct3_t funct3_sltu    = 3'b011;
  localparam funct3_t funct3_xor     = 3'b100;
  localparam funct3_t funct3_srl_sra = 3'b101;
  localparam funct3_t funct3_or      = 3'b110;
  localparam funct3_t funct3_and     = 3'b111;

  // Branch group
  localparam funct3_t funct3_beq  = 3'b000;
  localparam funct3_t funct3_bne  = 3'b001;
  localparam funct3_t funct3_blt  = 3'b100;
  localparam funct3_t funct3_bge  = 3'b101;
  localparam funct3_t funct3_bltu = 3'b110;
  localparam funct3_t funct3_bgeu = 3'b111;

  localparam funct7_t funct7_base = 7'b0000000;
  localparam funct7_t funct7_alt  = 7'b0100000; // SUB, SRA, SRAI

  typedef enum logic [4:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_lui,  // Immediate passes straight through
    alu_beq,
    alu_bne,
    alu_blt,
    alu_bge,
    alu_bltu,
    alu_bgeu
  } alu_op_t;

endpackage

`default_nettype wire
